// ==== source/id_queue_pkg.sv ====
// ID queue shared definitions
package id_queue_pkg;

    // Element sizes
    localparam int IdWidth   = 3;
    localparam int DataWidth = 8;
    localparam int Capacity  = 6;

    // Each ID owns at most one head-tail entry, so the table never needs more
    // entries than there are IDs or elements
    localparam int NIds       = 2 ** IdWidth;
    localparam int HtCapacity = (NIds < Capacity) ? NIds : Capacity;
    localparam int LdIdxWidth = $clog2(Capacity);
    localparam int HtIdxWidth = $clog2(HtCapacity);

    typedef logic [IdWidth-1:0]    id_t;
    typedef logic [DataWidth-1:0]  data_t;
    typedef logic [LdIdxWidth-1:0] ld_idx_t;
    typedef logic [HtIdxWidth-1:0] ht_idx_t;

    // One live ID with the first and last element of its chain
    typedef struct packed {
        id_t     id;
        ld_idx_t head;
        ld_idx_t tail;
        logic    free;
    } head_tail_t;

    // One stored element and the index of the next element with the same ID
    typedef struct packed {
        data_t   data;
        ld_idx_t next;
        logic    free;
    } linked_data_t;

    // Whole-entry write into the head-tail table
    typedef struct packed {
        logic       en;
        ht_idx_t    idx;
        head_tail_t entry;
    } ht_wr_t;

    // Allocation goes to the table's own first free slot
    typedef struct packed {
        logic    alloc_en;
        logic    link_en;
        ld_idx_t link_idx;
        data_t   alloc_data;
        logic    free_en;
        ld_idx_t free_idx;
    } ld_cmd_t;

endpackage

// ==== source/free_slot_finder.sv ====
// Lowest free slot encoder
`timescale 1ns/1ns

module free_slot_finder #(
    parameter int Width = 4,
    localparam int IdxWidth = (Width > 1) ? $clog2(Width) : 1
) (
    input  logic [Width-1:0]    free_i,
    output logic [IdxWidth-1:0] idx_o,
    output logic                any_o
);

    // Scan from the top down so that the lowest set bit is the last one written
    always_comb begin
        idx_o = '0;
        for (int i = Width - 1; i >= 0; i--) begin
            if (free_i[i]) begin
                idx_o = IdxWidth'(i);
            end
        end
    end

    // Index zero is also returned when nothing is free, so callers must check this flag
    assign any_o = |free_i;

endmodule

// ==== source/head_tail_table.sv ====
// Head-tail table
`timescale 1ns/1ns

module head_tail_table
    import id_queue_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  ht_wr_t     wr_i,
    input  id_t        id_i,
    input  logic       match_en_i,
    output logic       hit_o,
    output ht_idx_t    hit_idx_o,
    output head_tail_t hit_entry_o,
    output ht_idx_t    free_idx_o
);

    head_tail_t [HtCapacity-1:0] entries_q;
    logic       [HtCapacity-1:0] match;
    logic       [HtCapacity-1:0] free_vec;

    // Only live entries take part in the ID match
    for (genvar i = 0; i < HtCapacity; i++) begin : gen_match
        assign match[i]    = match_en_i && !entries_q[i].free && (entries_q[i].id == id_i);
        assign free_vec[i] = entries_q[i].free;
    end

    assign hit_o = |match;

    // The match vector is one-hot or zero, so ORing indices is a valid encoding
    always_comb begin
        hit_idx_o = '0;
        for (int i = 0; i < HtCapacity; i++) begin
            if (match[i]) begin
                hit_idx_o = hit_idx_o | ht_idx_t'(i);
            end
        end
    end

    assign hit_entry_o = entries_q[hit_idx_o];

    // There is always a free entry when the element storage has room
    free_slot_finder #(
        .Width (HtCapacity)
    ) free_slot_finder_inst (
        .free_i (free_vec),
        .idx_o  (free_idx_o),
        .any_o  ()
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < HtCapacity; i++) begin
                entries_q[i] <= '{id: '0, head: '0, tail: '0, free: 1'b1};
            end
        end else if (wr_i.en) begin
            entries_q[wr_i.idx] <= wr_i.entry;
        end
    end

    // A second live entry for one ID would split its FIFO order
    a_unique_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(match))
        else $error("More than one head-tail entry matches the ID");

endmodule

// ==== source/linked_data_table.sv ====
// Linked data table
`timescale 1ns/1ns

module linked_data_table
    import id_queue_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  ld_cmd_t                    cmd_i,
    input  ld_idx_t                    head_idx_i,
    output linked_data_t               head_o,
    output ld_idx_t                    alloc_idx_o,
    output logic                       full_o,
    output linked_data_t [Capacity-1:0] entries_o
);

    linked_data_t [Capacity-1:0] entries_q;
    logic         [Capacity-1:0] free_vec;
    logic                        any_free;

    for (genvar i = 0; i < Capacity; i++) begin : gen_free
        assign free_vec[i] = entries_q[i].free;
    end

    free_slot_finder #(
        .Width (Capacity)
    ) free_slot_finder_inst (
        .free_i (free_vec),
        .idx_o  (alloc_idx_o),
        .any_o  (any_free)
    );

    // The queue is full exactly when no element slot is free
    assign full_o    = !any_free;
    assign head_o    = entries_q[head_idx_i];
    assign entries_o = entries_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < Capacity; i++) begin
                entries_q[i] <= '{data: '0, next: '0, free: 1'b1};
            end
        end else begin
            if (cmd_i.alloc_en) begin
                entries_q[alloc_idx_o] <= '{data: cmd_i.alloc_data, next: '0, free: 1'b0};
                // Chain the new element behind the current tail of its ID
                if (cmd_i.link_en) begin
                    entries_q[cmd_i.link_idx].next <= alloc_idx_o;
                end
            end
            // Payload of a freed slot is left as it was
            if (cmd_i.free_en) begin
                entries_q[cmd_i.free_idx].free <= 1'b1;
            end
        end
    end

    a_no_alloc_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmd_i.alloc_en |-> !full_o)
        else $error("Element allocated while the queue is full");

    a_no_double_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmd_i.free_en |-> !entries_q[cmd_i.free_idx].free)
        else $error("Element slot freed twice");

endmodule

// ==== source/exists_lookup.sv ====
// Masked exists search
`timescale 1ns/1ns

module exists_lookup
    import id_queue_pkg::*;
(
    input  linked_data_t [Capacity-1:0] entries_i,
    input  logic                        req_i,
    input  data_t                       data_i,
    input  data_t                       mask_i,
    output logic                        gnt_o,
    output logic                        exists_o
);

    logic [Capacity-1:0] match;

    // A bit only counts as a mismatch where the mask is set
    for (genvar i = 0; i < Capacity; i++) begin : gen_cmp
        assign match[i] = !entries_i[i].free &&
                          (((entries_i[i].data ^ data_i) & mask_i) == '0);
    end

    // The search is always granted, so the grant just follows the request
    assign gnt_o    = req_i;
    assign exists_o = req_i && (|match);

endmodule

// ==== source/queue_ctrl.sv ====
// ID queue controller
`timescale 1ns/1ns

module queue_ctrl
    import id_queue_pkg::*;
(
    input  logic         inp_req_i,
    input  id_t          inp_id_i,
    input  data_t        inp_data_i,
    input  logic         oup_req_i,
    input  id_t          oup_id_i,
    input  logic         oup_pop_i,
    input  logic         full_i,
    input  logic         hit_i,
    input  ht_idx_t      hit_idx_i,
    input  head_tail_t   hit_entry_i,
    input  ht_idx_t      ht_free_idx_i,
    input  ld_idx_t      alloc_idx_i,
    input  linked_data_t head_i,
    output id_t          match_id_o,
    output logic         match_en_o,
    output ld_idx_t      head_idx_o,
    output ht_wr_t       ht_wr_o,
    output ld_cmd_t      ld_cmd_o,
    output logic         inp_gnt_o,
    output logic         oup_gnt_o,
    output data_t        oup_data_o,
    output logic         oup_data_valid_o
);

    logic push;

    // Push wins the cycle, and a read only goes through when no push does
    assign inp_gnt_o  = !full_i;
    assign push       = inp_req_i && inp_gnt_o;
    assign oup_gnt_o  = oup_req_i && !push;

    // One shared matcher serves whichever port owns the cycle
    assign match_id_o = push ? inp_id_i : oup_id_i;
    assign match_en_o = push || oup_gnt_o;
    assign head_idx_o = hit_entry_i.head;

    assign oup_data_valid_o = oup_gnt_o && hit_i;
    assign oup_data_o       = oup_data_valid_o ? head_i.data : '0;

    always_comb begin
        ht_wr_o  = '0;
        ld_cmd_o = '0;
        if (push) begin
            ld_cmd_o.alloc_en   = 1'b1;
            ld_cmd_o.alloc_data = inp_data_i;
            ht_wr_o.en          = 1'b1;
            if (hit_i) begin
                // Append behind the existing tail and move the tail forward
                ld_cmd_o.link_en   = 1'b1;
                ld_cmd_o.link_idx  = hit_entry_i.tail;
                ht_wr_o.idx        = hit_idx_i;
                ht_wr_o.entry      = hit_entry_i;
                ht_wr_o.entry.tail = alloc_idx_i;
            end else begin
                // First element of this ID opens a new head-tail entry
                ht_wr_o.idx   = ht_free_idx_i;
                ht_wr_o.entry = '{id: inp_id_i, head: alloc_idx_i, tail: alloc_idx_i,
                                  free: 1'b0};
            end
        end else if (oup_data_valid_o && oup_pop_i) begin
            ld_cmd_o.free_en  = 1'b1;
            ld_cmd_o.free_idx = hit_entry_i.head;
            ht_wr_o.en        = 1'b1;
            ht_wr_o.idx       = hit_idx_i;
            if (hit_entry_i.head == hit_entry_i.tail) begin
                // Last element of the ID leaves, so the ID entry goes too
                ht_wr_o.entry = '{id: '0, head: '0, tail: '0, free: 1'b1};
            end else begin
                ht_wr_o.entry      = hit_entry_i;
                ht_wr_o.entry.head = head_i.next;
            end
        end
    end

endmodule

// ==== source/id_queue.sv ====
// ID queue top level
`timescale 1ns/1ns

module id_queue
    import id_queue_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  inp_req_i,
    input  id_t   inp_id_i,
    input  data_t inp_data_i,
    output logic  inp_gnt_o,
    input  logic  oup_req_i,
    input  id_t   oup_id_i,
    input  logic  oup_pop_i,
    output logic  oup_gnt_o,
    output data_t oup_data_o,
    output logic  oup_data_valid_o,
    input  logic  exists_req_i,
    input  data_t exists_data_i,
    input  data_t exists_mask_i,
    output logic  exists_gnt_o,
    output logic  exists_o
);

    ht_wr_t                      ht_wr;
    ld_cmd_t                     ld_cmd;
    id_t                         match_id;
    logic                        match_en;
    logic                        hit;
    ht_idx_t                     hit_idx;
    head_tail_t                  hit_entry;
    ht_idx_t                     ht_free_idx;
    ld_idx_t                     head_idx;
    linked_data_t                head;
    ld_idx_t                     alloc_idx;
    logic                        full;
    linked_data_t [Capacity-1:0] ld_entries;

    queue_ctrl queue_ctrl_inst (
        .inp_req_i        (inp_req_i),
        .inp_id_i         (inp_id_i),
        .inp_data_i       (inp_data_i),
        .oup_req_i        (oup_req_i),
        .oup_id_i         (oup_id_i),
        .oup_pop_i        (oup_pop_i),
        .full_i           (full),
        .hit_i            (hit),
        .hit_idx_i        (hit_idx),
        .hit_entry_i      (hit_entry),
        .ht_free_idx_i    (ht_free_idx),
        .alloc_idx_i      (alloc_idx),
        .head_i           (head),
        .match_id_o       (match_id),
        .match_en_o       (match_en),
        .head_idx_o       (head_idx),
        .ht_wr_o          (ht_wr),
        .ld_cmd_o         (ld_cmd),
        .inp_gnt_o        (inp_gnt_o),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_o       (oup_data_o),
        .oup_data_valid_o (oup_data_valid_o)
    );

    head_tail_table head_tail_table_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .wr_i        (ht_wr),
        .id_i        (match_id),
        .match_en_i  (match_en),
        .hit_o       (hit),
        .hit_idx_o   (hit_idx),
        .hit_entry_o (hit_entry),
        .free_idx_o  (ht_free_idx)
    );

    linked_data_table linked_data_table_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cmd_i       (ld_cmd),
        .head_idx_i  (head_idx),
        .head_o      (head),
        .alloc_idx_o (alloc_idx),
        .full_o      (full),
        .entries_o   (ld_entries)
    );

    // The search sees the stored elements directly and ignores the other ports
    exists_lookup exists_lookup_inst (
        .entries_i (ld_entries),
        .req_i     (exists_req_i),
        .data_i    (exists_data_i),
        .mask_i    (exists_mask_i),
        .gnt_o     (exists_gnt_o),
        .exists_o  (exists_o)
    );

endmodule

// ==== dv/tb_id_queue.sv ====
// ID queue testbench
`timescale 1ns/1ns

module tb_id_queue
    import id_queue_pkg::*;
();

    localparam int RandOps = 200;
    // Reset, fill and drain, ordering, peek, absent ID, priority and the random mix
    localparam int StimCycles = 2 + (2 * Capacity + 1) + 2 * Capacity + 6 + 1 + 8 + RandOps;
    localparam int TimeoutCycles = 2 * StimCycles;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  inp_req;
    id_t   inp_id;
    data_t inp_data;
    logic  inp_gnt;
    logic  oup_req;
    id_t   oup_id;
    logic  oup_pop;
    logic  oup_gnt;
    data_t oup_data;
    logic  oup_data_valid;
    logic  exists_req;
    data_t exists_data;
    data_t exists_mask;
    logic  exists_gnt;
    logic  exists;

    // Reference model holds one FIFO per ID, oldest element at position zero
    data_t  fifo_data [NIds][Capacity];
    int     fifo_cnt [NIds];
    int     total_cnt;
    int     errors;
    int     checks;
    int     test_base;
    int     cycle_cnt = 0;
    integer seed;

    id_queue id_queue_inst (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .inp_req_i        (inp_req),
        .inp_id_i         (inp_id),
        .inp_data_i       (inp_data),
        .inp_gnt_o        (inp_gnt),
        .oup_req_i        (oup_req),
        .oup_id_i         (oup_id),
        .oup_pop_i        (oup_pop),
        .oup_gnt_o        (oup_gnt),
        .oup_data_o       (oup_data),
        .oup_data_valid_o (oup_data_valid),
        .exists_req_i     (exists_req),
        .exists_data_i    (exists_data),
        .exists_mask_i    (exists_mask),
        .exists_gnt_o     (exists_gnt),
        .exists_o         (exists)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TimeoutCycles) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input data_t got, input data_t exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    // A stored value agrees with the search word when every masked bit is equal
    function automatic logic agrees_on_mask(input data_t value, input data_t pattern,
                                            input data_t mask);
        for (int b = 0; b < DataWidth; b++) begin
            if (mask[b] && (value[b] != pattern[b])) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // One stimulus cycle: drive on the falling edge, check before the rising edge
    task automatic run_cycle(input logic in_req, input id_t in_id, input data_t in_data,
                             input logic out_req, input id_t out_id, input logic pop,
                             input logic ex_req, input data_t ex_data, input data_t ex_mask);
        logic  exp_inp_gnt;
        logic  push;
        logic  exp_oup_gnt;
        logic  exp_valid;
        data_t exp_data;
        logic  exp_exists;
        @(negedge clk);
        inp_req     = in_req;
        inp_id      = in_id;
        inp_data    = in_data;
        oup_req     = out_req;
        oup_id      = out_id;
        oup_pop     = pop;
        exists_req  = ex_req;
        exists_data = ex_data;
        exists_mask = ex_mask;
        #5;
        // Push wins whenever there is room, and a read only goes through without one
        exp_inp_gnt = total_cnt < Capacity;
        push        = in_req && exp_inp_gnt;
        exp_oup_gnt = out_req && !push;
        exp_valid   = exp_oup_gnt && (fifo_cnt[out_id] > 0);
        exp_data    = exp_valid ? fifo_data[out_id][0] : '0;
        exp_exists  = 1'b0;
        for (int i = 0; i < NIds; i++) begin
            for (int k = 0; k < fifo_cnt[i]; k++) begin
                if (agrees_on_mask(fifo_data[i][k], ex_data, ex_mask)) begin
                    exp_exists = ex_req;
                end
            end
        end
        checks += 6;
        if (inp_gnt !== exp_inp_gnt) report_mismatch("inp_gnt_o", data_t'(inp_gnt),
                                                     data_t'(exp_inp_gnt));
        if (oup_gnt !== exp_oup_gnt) report_mismatch("oup_gnt_o", data_t'(oup_gnt),
                                                     data_t'(exp_oup_gnt));
        if (oup_data_valid !== exp_valid) report_mismatch("oup_data_valid_o",
                                                          data_t'(oup_data_valid),
                                                          data_t'(exp_valid));
        if (oup_data !== exp_data) report_mismatch("oup_data_o", oup_data, exp_data);
        if (exists_gnt !== ex_req) report_mismatch("exists_gnt_o", data_t'(exists_gnt),
                                                   data_t'(ex_req));
        if (exists !== exp_exists) report_mismatch("exists_o", data_t'(exists),
                                                   data_t'(exp_exists));
        if (push) begin
            fifo_data[in_id][fifo_cnt[in_id]] = in_data;
            fifo_cnt[in_id]++;
            total_cnt++;
        end else if (exp_valid && pop) begin
            for (int k = 0; k < Capacity - 1; k++) begin
                fifo_data[out_id][k] = fifo_data[out_id][k + 1];
            end
            fifo_cnt[out_id]--;
            total_cnt--;
        end
    endtask

    // Pop every ID until the model says it is empty
    task automatic drain_all();
        for (int i = 0; i < NIds; i++) begin
            while (fifo_cnt[i] > 0) begin
                run_cycle(1'b0, '0, '0, 1'b1, id_t'(i), 1'b1, 1'b0, '0, '0);
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        data_t mask;
        seed      = 11148;
        errors    = 0;
        checks    = 0;
        test_base = 0;
        total_cnt = 0;
        for (int i = 0; i < NIds; i++) begin
            fifo_cnt[i] = 0;
        end
        rst_n       = 1'b0;
        inp_req     = 1'b0;
        inp_id      = '0;
        inp_data    = '0;
        oup_req     = 1'b0;
        oup_id      = '0;
        oup_pop     = 1'b0;
        exists_req  = 1'b0;
        exists_data = '0;
        exists_mask = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // One push more than fits, so the grant must drop on the last one
        for (int n = 0; n <= Capacity; n++) begin
            run_cycle(1'b1, id_t'($random(seed)), data_t'($random(seed)),
                      1'b0, '0, 1'b0, 1'b0, '0, '0);
        end
        drain_all();
        end_test("fill to capacity");

        // A few IDs share the queue so that their chains interleave
        for (int n = 0; n < Capacity; n++) begin
            run_cycle(1'b1, id_t'($random(seed) & 3), data_t'($random(seed)),
                      1'b0, '0, 1'b0, 1'b0, '0, '0);
        end
        drain_all();
        end_test("fifo order per id");

        for (int n = 0; n < 2; n++) begin
            run_cycle(1'b1, id_t'(5), data_t'($random(seed)), 1'b0, '0, 1'b0, 1'b0, '0, '0);
        end
        for (int n = 0; n < 4; n++) begin
            run_cycle(1'b0, '0, '0, 1'b1, id_t'(5), n >= 2, 1'b0, '0, '0);
        end
        end_test("non-destructive read");

        run_cycle(1'b0, '0, '0, 1'b1, id_t'(7), 1'b1, 1'b0, '0, '0);
        end_test("absent id");

        // Each pop request here collides with a push and must be refused
        for (int n = 0; n < 4; n++) begin
            run_cycle(1'b1, id_t'(2), data_t'($random(seed)), 1'b1, id_t'(2), 1'b1,
                      1'b0, '0, '0);
        end
        drain_all();
        end_test("push priority");

        // Narrow data and masks so that searches hit often, with some all-zero masks
        for (int n = 0; n < RandOps; n++) begin
            mask = (($random(seed) & 7) == 0) ? '0 : data_t'($random(seed) & 15);
            run_cycle(1'($random(seed)), id_t'($random(seed)), data_t'($random(seed) & 15),
                      1'($random(seed)), id_t'($random(seed)), 1'($random(seed)),
                      (($random(seed) & 3) != 0), data_t'($random(seed) & 15), mask);
        end
        end_test("masked exists search");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/id_queue_pkg.sv
source/free_slot_finder.sv
source/head_tail_table.sv
source/linked_data_table.sv
source/exists_lookup.sv
source/queue_ctrl.sv
source/id_queue.sv
dv/tb_id_queue.sv

// ==== Makefile ====
TOP = tb_id_queue

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
